// ==== verilog.f ====
verilog/cpu_timing_pkg.sv
verilog/axil_pkg.sv
verilog/cen_frac_gen.sv
verilog/bus_wait_gate.sv
verilog/eq_phase_gen.sv
verilog/cpu_timing_regs.sv
verilog/cpu_timing_top.sv
dv/tb_cpu_timing.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       := tb_cpu_timing
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_cpu_timing.sv ====
module tb_cpu_timing;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cycles = 4000;   // about twice the whole run

    logic                clk;
    logic                rstn;
    axil_pkg::axil_req_t axil_req;
    axil_pkg::axil_rsp_t axil_rsp;
    logic                bus_busy;
    logic                rom_cs;
    logic                rom_ok;
    logic                cen_e;
    logic                cen_q;
    logic                cpu_cen;

    string           test_name = "reset";
    logic [31:0]     seed = 32'h25ad;
    int              cyc = 0;
    int              last_e_cyc;        // cycle of the latest cen_e
    int              last_eq_cyc;       // cycle of the latest cen_e or cen_q
    logic            last_was_e;
    int              gap_e;
    int              gap_eq;
    logic            stall_in;          // cpu must wait this clock
    logic            eq_pulse;
    logic            idle_chk;
    logic            rate_chk;
    logic            nocu_chk;
    logic            cu_chk;
    logic            cu_end;
    logic            stall_cnt_on;
    logic            ecnt_on;
    int              e_gap;             // expected clocks between cen_e
    int              stall_seen;
    int              e_seen;
    int              cu_pulses;
    int              fast_gaps;         // one clock gaps during catch-up
    logic            slow_seen;
    axil_pkg::data_t rd_exp;
    axil_pkg::resp_t rresp_exp;
    logic            rd_nonzero;        // read only has to be nonzero

    cpu_timing_top i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .bus_busy (bus_busy),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .cen_e    (cen_e),
        .cen_q    (cen_q),
        .cpu_cen  (cpu_cen)
    );

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign stall_in = bus_busy || (rom_cs && !rom_ok);
    assign eq_pulse = cen_e || cen_q;
    assign gap_e    = cyc - last_e_cyc;
    assign gap_eq   = cyc - last_eq_cyc;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == max_cycles)
            report_fail($sformatf("timeout, run still going after %0d cycles", max_cycles));
    end

    // reference bookkeeping from the observed enables
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_e_cyc  <= 0;
            last_eq_cyc <= 0;
            last_was_e  <= 1'b0;    // first enable after reset is E
            stall_seen  <= 0;
            e_seen      <= 0;
            cu_pulses   <= 0;
            fast_gaps   <= 0;
            slow_seen   <= 1'b0;
        end else begin
            if (cen_e)
                last_e_cyc <= cyc;
            if (eq_pulse) begin
                last_eq_cyc <= cyc;
                last_was_e  <= cen_e;
            end
            stall_seen <= stall_cnt_on ? stall_seen + int'(stall_in) : 0;
            e_seen     <= ecnt_on ? e_seen + int'(cen_e) : 0;
            if (!cu_chk) begin
                cu_pulses <= 0;
                fast_gaps <= 0;
                slow_seen <= 1'b0;
            end else if (eq_pulse) begin
                cu_pulses <= cu_pulses + 1;     // first one closes the stall gap
                if (cu_pulses != 0 && gap_eq == 1)
                    fast_gaps <= fast_gaps + 1;
                if (cu_pulses != 0 && gap_eq == 2)
                    slow_seen <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) idle_chk |-> !eq_pulse)
        else report_fail($sformatf("Error %s: enables expected 00 actual %b",
                                   test_name, $sampled({cen_e, cen_q})));
    assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.rvalid && axil_req.rready && !rd_nonzero
        |-> {axil_rsp.rresp, axil_rsp.rdata} == {rresp_exp, rd_exp})
        else report_fail($sformatf("Error %s: resp/rdata expected %h actual %h", test_name,
                                   {rresp_exp, rd_exp},
                                   $sampled({axil_rsp.rresp, axil_rsp.rdata})));
    assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.rvalid && axil_req.rready && rd_nonzero
        |-> axil_rsp.rresp == axil_pkg::resp_okay && axil_rsp.rdata != '0)
        else report_fail($sformatf("Error %s: rdata expected nonzero actual %h",
                                   test_name, $sampled(axil_rsp.rdata)));
    assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.bvalid && axil_req.bready |-> axil_rsp.bresp == axil_pkg::resp_okay)
        else report_fail($sformatf("Error %s: bresp expected %h actual %h", test_name,
                                   axil_pkg::resp_okay, $sampled(axil_rsp.bresp)));
    // aw and w accepted in the same cycle
    assert property (@(posedge clk) disable iff (!rstn) axil_rsp.wready == axil_rsp.awready)
        else report_fail($sformatf("Error %s: wready expected %b actual %b", test_name,
                                   $sampled(axil_rsp.awready), $sampled(axil_rsp.wready)));
    assert property (@(posedge clk) disable iff (!rstn) stall_in |-> !eq_pulse)
        else report_fail($sformatf("Error %s: enables while waiting expected 00 actual %b",
                                   test_name, $sampled({cen_e, cen_q})));
    assert property (@(posedge clk) disable iff (!rstn) eq_pulse |-> cen_e != last_was_e)
        else report_fail($sformatf("Error %s: cen_e expected %b actual %b", test_name,
                                   $sampled(!last_was_e), $sampled(cen_e)));
    assert property (@(posedge clk) disable iff (!rstn) cpu_cen == cen_q)
        else report_fail($sformatf("Error %s: cpu_cen expected %b actual %b", test_name,
                                   $sampled(cen_q), $sampled(cpu_cen)));
    assert property (@(posedge clk) disable iff (!rstn) rate_chk && cen_e |-> gap_e == e_gap)
        else report_fail($sformatf("Error %s: cen_e gap expected %0d actual %0d",
                                   test_name, e_gap, $sampled(gap_e)));
    assert property (@(posedge clk) disable iff (!rstn)
        rate_chk && cen_q |-> gap_e == e_gap / 2)
        else report_fail($sformatf("Error %s: cen_q offset expected %0d actual %0d",
                                   test_name, e_gap / 2, $sampled(gap_e)));
    assert property (@(posedge clk) disable iff (!rstn) nocu_chk && eq_pulse |-> gap_eq >= 2)
        else report_fail($sformatf("Error %s: enable gap expected at least 2 actual %0d",
                                   test_name, $sampled(gap_eq)));
    assert property (@(posedge clk) disable iff (!rstn)
        cu_chk && eq_pulse && cu_pulses != 0 && !slow_seen |-> gap_eq == 1 || gap_eq == 2)
        else report_fail($sformatf("Error %s: catch-up gap expected 1 or 2 actual %0d",
                                   test_name, $sampled(gap_eq)));
    assert property (@(posedge clk) disable iff (!rstn)
        cu_chk && eq_pulse && slow_seen |-> gap_eq == 2)
        else report_fail($sformatf("Error %s: gap after catch-up expected 2 actual %0d",
                                   test_name, $sampled(gap_eq)));
    assert property (@(posedge clk) disable iff (!rstn) cu_end |-> fast_gaps != 0)
        else report_fail($sformatf("Error %s: fast gaps expected nonzero actual %0d",
                                   test_name, $sampled(fast_gaps)));

    // inputs settle 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic axil_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        while (!axil_rsp.awready)
            step();
        step();                         // aw and w handshake
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        while (!axil_rsp.bvalid)
            step();
        step();
        axil_req.bready = 1'b0;
    endtask

    task automatic read_check(input axil_pkg::addr_t addr, input axil_pkg::data_t exp,
                              input axil_pkg::resp_t resp);
        rd_exp           = exp;
        rresp_exp        = resp;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        while (!axil_rsp.arready)
            step();
        step();
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        while (!axil_rsp.rvalid)
            step();
        step();                         // data checked on this edge
        axil_req.rready = 1'b0;
    endtask

    task automatic wait_cen_e(input int count);
        for (int i = 0; i < count; i++) begin
            while (!cen_e)
                step();
            step();
        end
    endtask

    task automatic random_stalls(input int clocks);
        for (int i = 0; i < clocks; i++) begin
            seed     = lcg_step(seed);
            bus_busy = seed[31:29] == 3'd0;     // about one clock in eight
            rom_cs   = (i / 64) % 2 == 1;       // rom fetch phases
            rom_ok   = seed[27:26] != 2'd0;     // sdram late one time in four
            step();
        end
        bus_busy = 1'b0;
        rom_cs   = 1'b0;
        rom_ok   = 1'b1;
    endtask

    initial begin
        rstn         = 1'b0;
        axil_req     = '0;
        bus_busy     = 1'b0;
        rom_cs       = 1'b0;
        rom_ok       = 1'b1;
        idle_chk     = 1'b0;
        rate_chk     = 1'b0;
        nocu_chk     = 1'b0;
        cu_chk       = 1'b0;
        cu_end       = 1'b0;
        stall_cnt_on = 1'b0;
        ecnt_on      = 1'b0;
        e_gap        = 4;
        rd_exp       = '0;
        rresp_exp    = axil_pkg::resp_okay;
        rd_nonzero   = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstn = 1'b1;

        test_name = "reset_regs";
        idle_chk  = 1'b1;                       // generator still off
        repeat (4) step();
        read_check(cpu_timing_pkg::reg_ctrl, 32'h0, axil_pkg::resp_okay);
        read_check(cpu_timing_pkg::reg_ratio, 32'h0101, axil_pkg::resp_okay);
        axil_write(cpu_timing_pkg::reg_ratio, 32'h0201);   // num 1 den 2
        axil_write(cpu_timing_pkg::reg_ctrl, 32'h2);       // catch-up only
        read_check(cpu_timing_pkg::reg_ratio, 32'h0201, axil_pkg::resp_okay);
        read_check(cpu_timing_pkg::reg_ctrl, 32'h2, axil_pkg::resp_okay);
        axil_write(cpu_timing_pkg::reg_ratio, 32'h0003);   // den 0, dropped
        axil_write(cpu_timing_pkg::reg_ratio, 32'h0203);   // num above den, dropped
        read_check(cpu_timing_pkg::reg_ratio, 32'h0201, axil_pkg::resp_okay);
        read_check(8'h14, 32'h0, axil_pkg::resp_slverr);
        idle_chk = 1'b0;

        test_name = "rate_1_1";
        axil_write(cpu_timing_pkg::reg_ratio, 32'h0101);
        axil_write(cpu_timing_pkg::reg_ctrl, 32'h1);
        wait_cen_e(2);
        e_gap    = 4;
        rate_chk = 1'b1;
        repeat (40) step();
        rate_chk  = 1'b0;
        test_name = "rate_1_2";
        axil_write(cpu_timing_pkg::reg_ratio, 32'h0201);
        wait_cen_e(2);                          // old cadence flushed
        e_gap    = 8;
        rate_chk = 1'b1;
        repeat (64) step();
        rate_chk = 1'b0;

        test_name = "stall_count";
        axil_write(cpu_timing_pkg::reg_ratio, 32'h0101);
        axil_write(cpu_timing_pkg::reg_stall, 32'h0);      // clear
        stall_cnt_on = 1'b1;
        random_stalls(600);
        repeat (2) step();
        read_check(cpu_timing_pkg::reg_stall, stall_seen, axil_pkg::resp_okay);
        stall_cnt_on = 1'b0;

        test_name = "no_catchup";
        nocu_chk  = 1'b1;
        random_stalls(800);
        repeat (4) step();
        nocu_chk = 1'b0;
        read_check(cpu_timing_pkg::reg_misses, 32'h0, axil_pkg::resp_okay);

        test_name = "catchup";
        axil_write(cpu_timing_pkg::reg_ctrl, 32'h3);
        wait_cen_e(2);
        stall_cnt_on = 1'b1;
        bus_busy     = 1'b1;
        repeat (2) step();
        rd_nonzero = 1'b1;                      // read while still stalled
        read_check(cpu_timing_pkg::reg_misses, 32'h0, axil_pkg::resp_okay);
        rd_nonzero = 1'b0;
        while (stall_seen < 8)
            step();
        bus_busy     = 1'b0;
        stall_cnt_on = 1'b0;
        cu_chk       = 1'b1;
        repeat (40) step();
        cu_end = 1'b1;
        step();
        cu_end = 1'b0;
        cu_chk = 1'b0;
        read_check(cpu_timing_pkg::reg_misses, 32'h0, axil_pkg::resp_okay);

        test_name = "ecount";
        axil_write(cpu_timing_pkg::reg_ctrl, 32'h0);
        repeat (4) step();
        axil_write(cpu_timing_pkg::reg_ecount, 32'h0);
        ecnt_on = 1'b1;
        axil_write(cpu_timing_pkg::reg_ctrl, 32'h1);
        repeat (50) step();
        axil_write(cpu_timing_pkg::reg_ctrl, 32'h0);
        repeat (4) step();                      // last base enable drains
        read_check(cpu_timing_pkg::reg_ecount, e_seen, axil_pkg::resp_okay);
        ecnt_on = 1'b0;
        axil_write(cpu_timing_pkg::reg_ecount, 32'h0);
        read_check(cpu_timing_pkg::reg_ecount, 32'h0, axil_pkg::resp_okay);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== verilog/cpu_timing_top.sv ====
module cpu_timing_top (
    input  logic                clk,
    input  logic                rstn,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp,
    input  logic                bus_busy,
    input  logic                rom_cs,
    input  logic                rom_ok,
    output logic                cen_e,
    output logic                cen_q,
    output logic                cpu_cen
);

    cpu_timing_pkg::timing_cfg_t  cfg;
    cpu_timing_pkg::timing_stat_t stat;
    logic                         clr_stall;
    logic                         clr_ecount;
    logic                         base_cen;   // cpu input clock rate
    logic                         gate;

    cpu_timing_regs i_regs (
        .clk        (clk),
        .rstn       (rstn),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .cfg        (cfg),
        .stat       (stat),
        .clr_stall  (clr_stall),
        .clr_ecount (clr_ecount)
    );

    cen_frac_gen i_cen (
        .clk      (clk),
        .rstn     (rstn),
        .cfg      (cfg),
        .base_cen (base_cen)
    );

    // bus contention and sdram rom wait
    bus_wait_gate i_gate (
        .clk         (clk),
        .rstn        (rstn),
        .base_cen    (base_cen),
        .bus_busy    (bus_busy),
        .rom_cs      (rom_cs),
        .rom_ok      (rom_ok),
        .clr_stall   (clr_stall),
        .gate        (gate),
        .stall_count (stat.stall_count)
    );

    eq_phase_gen i_eq (
        .clk        (clk),
        .rstn       (rstn),
        .base_cen   (base_cen),
        .gate       (gate),
        .catchup_en (cfg.catchup_en),
        .clr_ecount (clr_ecount),
        .cen_e      (cen_e),
        .cen_q      (cen_q),
        .cpu_cen    (cpu_cen),
        .e_count    (stat.e_count),
        .misses     (stat.misses)
    );

endmodule

// ==== verilog/cpu_timing_regs.sv ====
module cpu_timing_regs (
    input  logic                         clk,
    input  logic                         rstn,
    input  axil_pkg::axil_req_t          axil_req,
    output axil_pkg::axil_rsp_t          axil_rsp,
    output cpu_timing_pkg::timing_cfg_t  cfg,
    input  cpu_timing_pkg::timing_stat_t stat,
    output logic                         clr_stall,   // one clock pulses
    output logic                         clr_ecount
);

    typedef enum logic [1:0] {wr_idle, wr_accept, wr_exec, wr_resp} wr_state_e;
    typedef enum logic [1:0] {rd_idle, rd_accept, rd_resp} rd_state_e;

    wr_state_e               wr_state;
    rd_state_e               rd_state;
    axil_pkg::addr_t         wr_addr;       // captured at handshake
    logic [15:0]             wr_data;       // only low half is mapped
    logic [1:0]              wr_strb;
    axil_pkg::resp_t         bresp_q;
    axil_pkg::data_t         rdata_q;
    axil_pkg::resp_t         rresp_q;
    axil_pkg::data_t         rd_val;
    axil_pkg::resp_t         rd_code;
    cpu_timing_pkg::ratio_t  new_num;
    cpu_timing_pkg::ratio_t  new_den;
    logic                    ratio_ok;
    logic                    wr_hit;

    // byte merge of the ratio register
    assign new_num  = wr_strb[0] ? wr_data[7:0]  : cfg.num;
    assign new_den  = wr_strb[1] ? wr_data[15:8] : cfg.den;
    assign ratio_ok = new_den != '0 && new_num <= new_den;   // keeps one pulse per clock

    assign wr_hit = wr_addr inside {cpu_timing_pkg::reg_ctrl, cpu_timing_pkg::reg_ratio,
                                    cpu_timing_pkg::reg_stall, cpu_timing_pkg::reg_misses,
                                    cpu_timing_pkg::reg_ecount};

    // statistic clears fire in the execute cycle
    assign clr_stall  = wr_state == wr_exec && wr_addr == cpu_timing_pkg::reg_stall;
    assign clr_ecount = wr_state == wr_exec && wr_addr == cpu_timing_pkg::reg_ecount;

    // write channel, aw and w taken together
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_state       <= wr_idle;
            bresp_q        <= axil_pkg::resp_okay;
            cfg.enable     <= 1'b0;
            cfg.catchup_en <= 1'b0;
            cfg.num        <= cpu_timing_pkg::num_rst;
            cfg.den        <= cpu_timing_pkg::den_rst;
        end else begin
            case (wr_state)
                wr_idle:
                    if (axil_req.awvalid && axil_req.wvalid)
                        wr_state <= wr_accept;
                wr_accept:
                    wr_state <= wr_exec;            // handshake this cycle
                wr_exec: begin
                    wr_state <= wr_resp;
                    bresp_q  <= wr_hit ? axil_pkg::resp_okay : axil_pkg::resp_slverr;
                    if (wr_addr == cpu_timing_pkg::reg_ctrl && wr_strb[0]) begin
                        cfg.enable     <= wr_data[0];
                        cfg.catchup_en <= wr_data[1];
                    end
                    if (wr_addr == cpu_timing_pkg::reg_ratio && ratio_ok) begin
                        cfg.num <= new_num;         // bad ratio dropped, still okay
                        cfg.den <= new_den;
                    end
                end
                wr_resp:
                    if (axil_req.bready)
                        wr_state <= wr_idle;
                default:
                    wr_state <= wr_idle;
            endcase
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (wr_state == wr_accept) begin
            wr_addr <= axil_req.awaddr;
            wr_data <= axil_req.wdata[15:0];
            wr_strb <= axil_req.wstrb[1:0];
        end
    end

    // read decode, statistics zero extended
    always_comb begin
        rd_val  = '0;
        rd_code = axil_pkg::resp_okay;
        case (axil_req.araddr)
            cpu_timing_pkg::reg_ctrl:   rd_val = {30'd0, cfg.catchup_en, cfg.enable};
            cpu_timing_pkg::reg_ratio:  rd_val = {16'd0, cfg.den, cfg.num};
            cpu_timing_pkg::reg_stall:  rd_val = {16'd0, stat.stall_count};
            cpu_timing_pkg::reg_misses: rd_val = {28'd0, stat.misses};
            cpu_timing_pkg::reg_ecount: rd_val = {16'd0, stat.e_count};
            default:                    rd_code = axil_pkg::resp_slverr;  // data stays 0
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle:   if (axil_req.arvalid) rd_state <= rd_accept;
                rd_accept: rd_state <= rd_resp;
                rd_resp:   if (axil_req.rready) rd_state <= rd_idle;
                default:   rd_state <= rd_idle;
            endcase
        end
    end

    // read payload, sampled with arready
    always_ff @(posedge clk) begin
        if (rd_state == rd_accept) begin
            rdata_q <= rd_val;
            rresp_q <= rd_code;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_state == wr_accept;
        axil_rsp.wready  = wr_state == wr_accept;
        axil_rsp.bvalid  = wr_state == wr_resp;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = rd_state == rd_accept;
        axil_rsp.rvalid  = rd_state == rd_resp;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

endmodule

// ==== verilog/eq_phase_gen.sv ====
module eq_phase_gen (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  base_cen,
    input  logic                  gate,
    input  logic                  catchup_en,
    input  logic                  clr_ecount,
    output logic                  cen_e,
    output logic                  cen_q,
    output logic                  cpu_cen,
    output cpu_timing_pkg::stat_t e_count,
    output cpu_timing_pkg::miss_t misses
);

    cpu_timing_pkg::phase_e phase;
    cpu_timing_pkg::phase_e phase_nxt;
    logic                   eq;         // E or Q this base enable
    logic                   last_eq;    // E or Q on the previous base enable
    logic                   catchup;
    logic                   run;        // base enable with bus free

    assign run     = base_cen && gate;
    assign cen_e   = run && phase == cpu_timing_pkg::ph_e;
    assign cen_q   = run && phase == cpu_timing_pkg::ph_q;
    assign cpu_cen = cen_q;             // cpu core clocks on Q
    assign eq      = cen_e || cen_q;
    assign catchup = misses != '0;

    // step one phase, or jump to the next E/Q when owed enables
    always_comb begin
        if (catchup)
            phase_nxt = phase[1] ? cpu_timing_pkg::ph_e : cpu_timing_pkg::ph_q;
        else
            phase_nxt = cpu_timing_pkg::phase_e'(phase + 2'd1);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase   <= cpu_timing_pkg::ph_e;   // first enable is E
            last_eq <= 1'b0;
            misses  <= '0;
        end else begin
            if (base_cen)
                last_eq <= eq;
            if (!catchup_en) begin
                misses <= '0;               // drop owed enables
            end else if (run && catchup) begin
                misses <= misses - 1'b1;
            end else if (base_cen && !gate && !eq && !last_eq
                         && misses != cpu_timing_pkg::miss_max) begin
                misses <= misses + 1'b1;    // whole enable slot lost
            end
            if (run)
                phase <= phase_nxt;         // frozen while gated
        end
    end

    // cen_e statistic
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            e_count <= '0;
        else if (clr_ecount)
            e_count <= '0;
        else if (cen_e && e_count != '1)
            e_count <= e_count + 1'b1;
    end

    assert property (@(posedge clk) disable iff (!rstn) $onehot0({cen_e, cen_q}))
        else $error("cen_e and cen_q together");

    assert property (@(posedge clk) disable iff (!rstn)
        (cen_e || cen_q) |-> gate && base_cen)
        else $error("enable fired while gated");

    // no debt builds up with catch-up off
    assert property (@(posedge clk) disable iff (!rstn) !catchup_en |=> misses == '0)
        else $error("misses counted with catch-up off");

endmodule

// ==== verilog/bus_wait_gate.sv ====
module bus_wait_gate (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  base_cen,
    input  logic                  bus_busy,     // shared bus taken by another master
    input  logic                  rom_cs,
    input  logic                  rom_ok,       // sdram data ready
    input  logic                  clr_stall,    // register write pulse
    output logic                  gate,         // high lets the cpu run
    output cpu_timing_pkg::stat_t stall_count
);

    logic rom_wait;
    logic stalled;      // base enable lost to a wait

    // rom access pending until sdram answers
    assign rom_wait = rom_cs && !rom_ok;
    assign gate     = !(bus_busy || rom_wait);
    assign stalled  = base_cen && !gate;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stall_count <= '0;
        end else if (clr_stall) begin
            stall_count <= '0;              // clear wins over a count
        end else if (stalled && stall_count != '1) begin
            stall_count <= stall_count + 1'b1;  // saturate at max
        end
    end

    // rom wait holds the cpu and is counted one clock later
    assert property (@(posedge clk) disable iff (!rstn)
        base_cen && rom_wait && !clr_stall && stall_count != '1
        |-> !gate ##1 stall_count == $past(stall_count) + 1'b1)
        else $error("rom wait not stalled or not counted");

endmodule

// ==== verilog/cen_frac_gen.sv ====
module cen_frac_gen (
    input  logic                        clk,
    input  logic                        rstn,
    input  cpu_timing_pkg::timing_cfg_t cfg,
    output logic                        base_cen    // num pulses every den clocks
);

    cpu_timing_pkg::acc_t acc;      // fractional remainder, always below den in steady state
    cpu_timing_pkg::acc_t sum;
    cpu_timing_pkg::acc_t den_ext;
    logic                 hit;

    assign sum     = acc + cpu_timing_pkg::acc_t'(cfg.num);
    assign den_ext = cpu_timing_pkg::acc_t'(cfg.den);
    assign hit     = sum >= den_ext;    // one subtraction is enough, num <= den

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc      <= '0;
            base_cen <= 1'b0;
        end else if (!cfg.enable) begin
            acc      <= '0;     // restart phase on next enable
            base_cen <= 1'b0;
        end else if (hit) begin
            acc      <= sum - den_ext;
            base_cen <= 1'b1;
        end else begin
            acc      <= sum;
            base_cen <= 1'b0;
        end
    end

    // a pulse always comes from an enabled clock before it
    assert property (@(posedge clk) disable iff (!rstn)
        $rose(base_cen) |-> $past(cfg.enable))
        else $error("base_cen rose without enable");

endmodule

// ==== verilog/axil_pkg.sv ====
package axil_pkg;

    typedef logic [7:0]  addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // master to slave
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        data_t wdata;
        strb_t wstrb;
        logic  bready;
        logic  arvalid;
        addr_t araddr;
        logic  rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
        logic  arready;
        logic  rvalid;
        data_t rdata;
        resp_t rresp;
    } axil_rsp_t;

endpackage

// ==== verilog/cpu_timing_pkg.sv ====
package cpu_timing_pkg;

    // widths that carry a meaning
    typedef logic [7:0]  ratio_t;   // enable ratio numerator / denominator
    typedef logic [15:0] stat_t;    // saturating statistic
    typedef logic [3:0]  miss_t;    // missed enables, saturates at 15

    localparam int acc_w = 9;       // holds num + acc without overflow
    typedef logic [acc_w-1:0] acc_t;

    localparam miss_t miss_max = 4'd15;

    // base enable phases inside one cpu cycle
    typedef enum logic [1:0] {
        ph_e  = 2'd0,   // E rises here
        ph_eq = 2'd1,
        ph_q  = 2'd2,   // Q rises here
        ph_qe = 2'd3
    } phase_e;

    typedef struct packed {
        logic   enable;      // generator on
        logic   catchup_en;  // recover missed enables
        ratio_t num;
        ratio_t den;
    } timing_cfg_t;

    typedef struct packed {
        stat_t stall_count;
        stat_t e_count;
        miss_t misses;
    } timing_stat_t;

    // register map, byte offsets
    localparam logic [7:0] reg_ctrl   = 8'h00;  // [0] enable, [1] catchup_en
    localparam logic [7:0] reg_ratio  = 8'h04;  // [7:0] num, [15:8] den
    localparam logic [7:0] reg_stall  = 8'h08;  // write clears
    localparam logic [7:0] reg_misses = 8'h0C;  // read only
    localparam logic [7:0] reg_ecount = 8'h10;  // write clears

    localparam ratio_t num_rst = 8'd1;  // 1/1 out of reset
    localparam ratio_t den_rst = 8'd1;

endpackage
